// File: sources.f
mem_pkg.sv
access_decode.sv
dmem_lanes.sv
periph_regs.sv
load_align.sv
mem_top.sv
tb_mem_top.sv

// File: Makefile
# Verilator build and run of the data memory pipeline testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_top \
		-f sources.f -Mdir obj_dir
	./obj_dir/Vtb_mem_top | tee $(LOG)
	@if grep -qx "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tb_mem_top.sv
/*
 * Testbench for mem_top: byte-level reference model, LFSR stimulus,
 * load checker, PWM high-time measurement and a watchdog
 */
`timescale 1ns/1ps

module tb_mem_top;
    import mem_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] LFSR_SEED  = 32'h08b2_6b98;
    localparam logic [31:0] LFSR_TAPS  = 32'hA300_0000;

    // RV32I load/store width codes
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // Cycle budget per test: reset, word, partial, unmapped, LEDs, micros
    localparam int TEST_CYCLES = 300 + 120 + 120 + 70 + 300 + 420;

    logic     clk;
    logic     rst_n;
    mem_req_t req;
    word_t    rdata;
    logic     led;
    logic     red;
    logic     green;
    logic     blue;

    byte_t       dmem_model [DMEM_WORDS * 4];
    word_t       duty_model;
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          errors_at_start;
    int          tests_run;

    // Expectation staged with the request, then delayed to the cycle the result is valid
    logic  want_check;
    word_t want_value;
    addr_t want_addr;
    logic  chk_en;
    word_t chk_value;
    addr_t chk_addr;

    mem_top mem_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rdata (rdata),
        .led   (led),
        .red   (red),
        .green (green),
        .blue  (blue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired after %0d ns, the tests did not complete", $time);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic void write_model_byte(input addr_t a, input byte_t b);
        if (a < DMEM_BYTES) begin
            dmem_model[a[11:0]] = b;
        end else if (a[31:2] == LEDS_ADDR[31:2]) begin
            duty_model[8 * int'(a[1:0]) +: 8] = b;
        end
    endfunction

    function automatic word_t model_word(input addr_t a);
        addr_t base;
        base = {a[31:2], 2'b00};
        if (a < DMEM_BYTES) begin
            return {dmem_model[base[11:0] + 12'd3], dmem_model[base[11:0] + 12'd2],
                    dmem_model[base[11:0] + 12'd1], dmem_model[base[11:0]]};
        end else if (a[31:2] == LEDS_ADDR[31:2]) begin
            return duty_model;
        end
        return '0;
    endfunction

    // Expected load result from the addressed word, the width code and the byte offset
    function automatic word_t expected_load(input word_t w, input funct3_t f, input offset_t off);
        logic [15:0] h;
        byte_t       b;
        h = off[1] ? w[31:16] : w[15:0];
        b = w[8 * int'(off) +: 8];
        case (f)
            F3_W:    return w;
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0000, h};
            F3_B:    return {{24{b[7]}}, b};
            default: return {24'h000000, b};
        endcase
    endfunction

    function automatic funct3_t load_width(input word_t r);
        case (r % 5)
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    function automatic addr_t unmapped_addr();
        addr_t a;
        a = random_bits(32);
        if (a < DMEM_BYTES) begin
            a = a | 32'h0000_1000;
        end
        if (a[31:4] == 28'hFFF_FFFF) begin
            a[31] = 1'b0;
        end
        a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_duty(input duty_t got, input duty_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic issue_req(input mem_req_t r, input logic chk, input word_t exp);
        @(posedge clk);
        req        <= r;
        want_check <= chk;
        want_value <= exp;
        want_addr  <= r.addr;
    endtask

    task automatic idle(input int cycles);
        mem_req_t r;
        r = '{write: 1'b0, funct3: F3_W, addr: '0, wdata: '0};
        repeat (cycles) issue_req(r, 1'b0, '0);
    endtask

    task automatic store(input addr_t a, input funct3_t f, input word_t d);
        mem_req_t r;
        int       nbytes;
        nbytes = f[1] ? 4 : (f[0] ? 2 : 1);
        for (int i = 0; i < nbytes; i++) begin
            write_model_byte(a + addr_t'(i), d[8 * i +: 8]);
        end
        r = '{write: 1'b1, funct3: f, addr: a, wdata: d};
        issue_req(r, 1'b0, '0);
    endtask

    task automatic load(input addr_t a, input funct3_t f);
        mem_req_t r;
        r = '{write: 1'b0, funct3: f, addr: a, wdata: '0};
        issue_req(r, 1'b1, expected_load(model_word(a), f, a[1:0]));
    endtask

    // Word load whose result is returned rather than checked
    task automatic sample_load(input addr_t a, output word_t v);
        mem_req_t r;
        r = '{write: 1'b0, funct3: F3_W, addr: a, wdata: '0};
        issue_req(r, 1'b0, '0);
        idle(1);
        @(negedge clk);
        v = rdata;
    endtask

    task automatic measure_pwm(input word_t duty);
        int         high [4];
        logic [3:0] outs;
        string      names [4];
        names = '{"blue", "green", "red", "led"};
        for (int i = 0; i < 4; i++) begin
            high[i] = 0;
        end
        idle(1);
        repeat (256) begin
            @(negedge clk);
            outs = {led, red, green, blue};
            for (int i = 0; i < 4; i++) begin
                if (outs[i]) high[i]++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (high[i] > 255) begin
                checks++;
                errors++;
                $display("%s output stayed high for all 256 cycles", names[i]);
            end else begin
                check_duty(duty_t'(high[i]), duty[8 * i +: 8], {names[i], " high cycles"});
            end
        end
    endtask

    task automatic end_test(input string name);
        idle(2);
        @(negedge clk);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-10s pass", name);
        end else begin
            $display("test %-10s fail with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chk_en    <= 1'b0;
            chk_value <= '0;
            chk_addr  <= '0;
        end else begin
            chk_en    <= want_check;
            chk_value <= want_value;
            chk_addr  <= want_addr;
        end
    end

    // The result of a load sampled at the last rising edge is stable here
    always @(negedge clk) begin
        if (chk_en) begin
            check_word(rdata, chk_value, $sformatf("load from %h", chk_addr));
        end
    end

    initial begin
        addr_t   a;
        word_t   w;
        word_t   first;
        word_t   second;
        funct3_t f;
        int      k;
        int      diff;
        addr_t   word_addrs [$];

        rst_n           = 1'b0;
        req             = '0;
        want_check      = 1'b0;
        want_value      = '0;
        want_addr       = '0;
        duty_model      = '0;
        lfsr_state      = LFSR_SEED;
        checks          = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        for (int i = 0; i < DMEM_WORDS * 4; i++) begin
            dmem_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_word(rdata, '0, "rdata after reset");
        load(LEDS_ADDR, F3_W);
        load(LEDS_ADDR + 32'd1, F3_B);
        measure_pwm(duty_model);
        end_test("reset");

        for (int n = 0; n < 32; n++) begin
            w = random_bits(10);
            a = {20'h00000, w[9:0], 2'b00};
            word_addrs.push_back(a);
            store(a, F3_W, random_bits(32));
            load(a, F3_W);
        end
        foreach (word_addrs[i]) begin
            load(word_addrs[i], F3_W);
        end
        end_test("word");

        // A 64-byte window keeps the loads landing on freshly merged lanes
        for (int n = 0; n < 48; n++) begin
            w = random_bits(6);
            a = addr_t'(32'h100) + {26'h0, w[5:0]};
            if (random_bits(1) != 0) begin
                a[0] = 1'b0;
                store(a, F3_H, random_bits(32));
            end else begin
                store(a, F3_B, random_bits(32));
            end
        end
        for (int n = 0; n < 48; n++) begin
            w = random_bits(6);
            a = addr_t'(32'h100) + {26'h0, w[5:0]};
            k = int'(random_bits(3));
            f = load_width(k);
            if (f[1]) begin
                a[1:0] = 2'b00;
            end else if (f[0]) begin
                a[0] = 1'b0;
            end
            load(a, f);
        end
        end_test("partial");

        for (int n = 0; n < 16; n++) begin
            a = unmapped_addr();
            store(a, F3_W, random_bits(32));
            load({20'h00000, a[11:2], 2'b00}, F3_W);
            load(a, load_width(random_bits(3)));
        end
        end_test("unmapped");

        store(LEDS_ADDR, F3_W, random_bits(32));
        load(LEDS_ADDR, F3_W);
        for (int n = 0; n < 2; n++) begin
            a = LEDS_ADDR + random_bits(2);
            store(a, F3_B, random_bits(32));
            load(a, F3_B);
            load(a, F3_BU);
        end
        load(LEDS_ADDR + 32'd2, F3_H);
        load(LEDS_ADDR, F3_W);
        measure_pwm(duty_model);
        end_test("leds");

        k = 100 + int'(random_bits(9) % 301);
        sample_load(MICROS_ADDR, first);
        idle(k - 2);
        sample_load(MICROS_ADDR, second);
        diff = int'(second - first);
        checks++;
        if (diff < k / TICKS_PER_MICROSECOND ||
            diff > (k + TICKS_PER_MICROSECOND - 1) / TICKS_PER_MICROSECOND) begin
            errors++;
            $display("mismatch at %0t: micros advanced by %0d over %0d cycles", $time, diff, k);
        end
        end_test("micros");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: mem_top.sv
/*
 * Top level of the data memory pipeline: decode, storage and peripherals, load align
 */
`timescale 1ns/1ps

module mem_top (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::word_t    rdata,
    output logic              led,
    output logic              red,
    output logic              green,
    output logic              blue
);
    import mem_pkg::*;

    lane_write_t lane_wr;
    load_ctl_t   load_ctl;
    word_t       dmem_rdata;
    word_t       periph_rdata;

    access_decode access_decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .lane_wr  (lane_wr),
        .load_ctl (load_ctl)
    );

    dmem_lanes dmem_lanes_i (
        .clk        (clk),
        .lane_wr    (lane_wr),
        .dmem_rdata (dmem_rdata)
    );

    periph_regs periph_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_wr      (lane_wr),
        .periph_rdata (periph_rdata),
        .led          (led),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

    load_align load_align_i (
        .load_ctl     (load_ctl),
        .dmem_rdata   (dmem_rdata),
        .periph_rdata (periph_rdata),
        .rdata        (rdata)
    );

endmodule

// File: load_align.sv
/*
 * Stage three: picks memory or peripheral data, then extracts the addressed
 * byte or half-word and sign- or zero-extends it to a full word
 */
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::load_ctl_t load_ctl,
    input  mem_pkg::word_t     dmem_rdata,
    input  mem_pkg::word_t     periph_rdata,
    output mem_pkg::word_t     rdata
);
    import mem_pkg::*;

    word_t   src;
    word_t   shifted;
    offset_t shift_lanes;
    logic    is_word;
    logic    is_half;
    logic    is_unsigned;
    logic    sign_bit;

    assign is_word     = load_ctl.funct3[FUNCT3_WORD_BIT];
    assign is_half     = load_ctl.funct3[FUNCT3_HALF_BIT];
    assign is_unsigned = load_ctl.funct3[FUNCT3_UNSIGNED_BIT];

    assign src = (load_ctl.region == REGION_DMEM) ? dmem_rdata : periph_rdata;

    // Half-words only select on address bit 1
    assign shift_lanes = is_half ? {load_ctl.offset[1], 1'b0} : load_ctl.offset;
    assign shifted     = src >> {shift_lanes, 3'b000};

    always_comb begin
        if (is_word) begin
            sign_bit = 1'b0;
            rdata    = src;
        end else if (is_half) begin
            sign_bit = shifted[15] & ~is_unsigned;
            rdata    = {{16{sign_bit}}, shifted[15:0]};
        end else begin
            sign_bit = shifted[7] & ~is_unsigned;
            rdata    = {{24{sign_bit}}, shifted[7:0]};
        end
    end

endmodule

// File: periph_regs.sv
/*
 * Stage two peripherals: LED duty register with four 8-bit PWM outputs,
 * free-running microsecond counter and the registered peripheral read port
 */
`timescale 1ns/1ps

module periph_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_pkg::lane_write_t lane_wr,
    output mem_pkg::word_t       periph_rdata,
    output logic                 led,
    output logic                 red,
    output logic                 green,
    output logic                 blue
);
    import mem_pkg::*;

    // Lane 3 drives the user LED, lanes 2 to 0 drive red, green and blue
    duty_t     duty [4];
    duty_t     pwm_cnt;
    prescale_t prescale;
    word_t     micros;
    logic      leds_hit;

    assign leds_hit = (lane_wr.region == REGION_LEDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < 4; l++) begin
                duty[l] <= '0;
            end
        end else if (leds_hit) begin
            for (int l = 0; l < 4; l++) begin
                if (lane_wr.byte_en[l]) begin
                    duty[l] <= lane_wr.lane_data[8*l +: 8];
                end
            end
        end
    end

    // Wraps every 256 cycles, so each output is high for exactly duty cycles per period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + duty_t'(1);
        end
    end

    assign led   = (pwm_cnt < duty[3]);
    assign red   = (pwm_cnt < duty[2]);
    assign green = (pwm_cnt < duty[1]);
    assign blue  = (pwm_cnt < duty[0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
            micros   <= '0;
        end else if (prescale == PRESCALE_MAX) begin
            prescale <= '0;
            micros   <= micros + word_t'(1);
        end else begin
            prescale <= prescale + prescale_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            periph_rdata <= '0;
        end else begin
            case (lane_wr.region)
                REGION_LEDS:   periph_rdata <= {duty[3], duty[2], duty[1], duty[0]};
                REGION_MICROS: periph_rdata <= micros;
                default:       periph_rdata <= '0;
            endcase
        end
    end

    a_prescale_range: assert property (@(posedge clk) disable iff (!rst_n)
        prescale <= PRESCALE_MAX);

endmodule

// File: dmem_lanes.sv
/*
 * Stage two: 4 kB data memory built from four byte-wide lanes,
 * per-lane write enables and a registered read of the whole word
 */
`timescale 1ns/1ps

module dmem_lanes (
    input  logic                 clk,
    input  mem_pkg::lane_write_t lane_wr,
    output mem_pkg::word_t       dmem_rdata
);
    import mem_pkg::*;

    byte_t rd_lane [4];
    logic  dmem_hit;

    assign dmem_hit = (lane_wr.region == REGION_DMEM);

    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        byte_t mem [DMEM_WORDS];

        // Memory contents come up as zero in simulation
        initial begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] = '0;
            end
        end

        always_ff @(posedge clk) begin
            if (dmem_hit && lane_wr.byte_en[lane]) begin
                mem[lane_wr.index] <= lane_wr.lane_data[8*lane +: 8];
            end
        end

        // Read every cycle regardless of region; the align stage picks the source
        always_ff @(posedge clk) begin
            rd_lane[lane] <= mem[lane_wr.index];
        end
    end

    assign dmem_rdata = {rd_lane[3], rd_lane[2], rd_lane[1], rd_lane[0]};

endmodule

// File: access_decode.sv
/*
 * Stage one: address region decode, store byte enables and lane-aligned write data,
 * plus the registered load control handed on to the alignment stage
 */
`timescale 1ns/1ps

module access_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_pkg::mem_req_t    req,
    output mem_pkg::lane_write_t lane_wr,
    output mem_pkg::load_ctl_t   load_ctl
);
    import mem_pkg::*;

    region_t  region;
    offset_t  offset;
    byte_en_t size_mask;
    word_t    aligned_data;
    logic     is_word;
    logic     is_half;

    assign offset  = req.addr[1:0];
    assign is_word = req.funct3[FUNCT3_WORD_BIT];
    assign is_half = req.funct3[FUNCT3_HALF_BIT];

    // Peripherals match on the word address so byte and half-word stores reach their lanes
    always_comb begin
        if (req.addr < DMEM_BYTES) begin
            region = REGION_DMEM;
        end else if (req.addr[31:2] == LEDS_ADDR[31:2]) begin
            region = REGION_LEDS;
        end else if (req.addr[31:2] == MICROS_ADDR[31:2]) begin
            region = REGION_MICROS;
        end else begin
            region = REGION_NONE;
        end
    end

    // Replicating the low bits puts the store data on whichever lanes get enabled
    always_comb begin
        if (is_word) begin
            size_mask    = 4'b1111;
            aligned_data = req.wdata;
        end else if (is_half) begin
            size_mask    = offset[1] ? 4'b1100 : 4'b0011;
            aligned_data = {2{req.wdata[15:0]}};
        end else begin
            size_mask    = byte_en_t'(1) << offset;
            aligned_data = {4{req.wdata[7:0]}};
        end
    end

    always_comb begin
        lane_wr.region    = region;
        lane_wr.byte_en   = req.write ? size_mask : '0;
        lane_wr.index     = req.addr[$clog2(DMEM_WORDS)+1:2];
        lane_wr.lane_data = aligned_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_ctl <= '{region: REGION_NONE, funct3: '0, offset: '0};
        end else begin
            load_ctl <= '{region: region, funct3: req.funct3, offset: offset};
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        is_word |-> offset == 2'd0);

    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (!is_word && is_half) |-> !offset[0]);

endmodule

// File: mem_pkg.sv
/*
 * Shared sizes, peripheral addresses and region codes for the data memory pipeline,
 * along with the vector types and the request, lane-write and load-control structs
 */
package mem_pkg;

    localparam int CLK_FREQ_HZ           = 12_000_000;
    localparam int TICKS_PER_MICROSECOND = CLK_FREQ_HZ / 1_000_000;
    localparam int DMEM_WORDS            = 1024;
    localparam int PRESCALE_W            = $clog2(TICKS_PER_MICROSECOND);

    typedef logic [31:0]                 addr_t;
    typedef logic [31:0]                 word_t;
    typedef logic [7:0]                  byte_t;
    typedef logic [$clog2(DMEM_WORDS)-1:0] word_index_t;
    typedef logic [3:0]                  byte_en_t;
    typedef logic [1:0]                  offset_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [1:0]                  region_t;
    typedef logic [7:0]                  duty_t;
    typedef logic [PRESCALE_W-1:0]       prescale_t;

    // Data memory occupies the bottom of the address space
    localparam addr_t DMEM_BYTES  = addr_t'(DMEM_WORDS * 4);
    localparam addr_t LEDS_ADDR   = 32'hFFFF_FFFC;
    localparam addr_t MICROS_ADDR = 32'hFFFF_FFF4;

    localparam prescale_t PRESCALE_MAX = prescale_t'(TICKS_PER_MICROSECOND - 1);

    localparam region_t REGION_DMEM   = 2'd0;
    localparam region_t REGION_LEDS   = 2'd1;
    localparam region_t REGION_MICROS = 2'd2;
    localparam region_t REGION_NONE   = 2'd3;

    // Bit positions inside the RV32I load/store funct3 field
    localparam int FUNCT3_HALF_BIT     = 0;
    localparam int FUNCT3_WORD_BIT     = 1;
    localparam int FUNCT3_UNSIGNED_BIT = 2;

    typedef struct packed {
        logic    write;
        funct3_t funct3;
        addr_t   addr;
        word_t   wdata;
    } mem_req_t;

    // Byte enables here are already qualified by the write strobe
    typedef struct packed {
        region_t     region;
        byte_en_t    byte_en;
        word_index_t index;
        word_t       lane_data;
    } lane_write_t;

    typedef struct packed {
        region_t region;
        funct3_t funct3;
        offset_t offset;
    } load_ctl_t;

endpackage
